//--- Bender.yml
package:
  name: dma_dram

sources:
  - include_dirs:
      - logic
    files:
      - logic/dma_pkg.sv
      - logic/dma_addr_if.sv
      - logic/dma_regs.sv
      - logic/dma_addr_gen.sv
      - logic/dma_xfer_seq.sv
      - logic/dma_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/dma_clk_gen.sv
      - sim/dma_props.sv
      - sim/dma_tb.sv

//--- logic/dma_addr_gen.sv
/*
 * DMA address generator: linear word counter, or row-aligned
 * counter that jumps to row start plus stride at each burst end
 */
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module dma_addr_gen (
	input  wire                clk,
	input  wire                rst_n,
	input  wire [`DMA_AW-1:0]  start_addr,
	dma_addr_if.gen            ai
);

	localparam logic [`DMA_AW-1:0] STRIDE_WIDE   = `DMA_STRIDE_WIDE;
	localparam logic [`DMA_AW-1:0] STRIDE_NARROW = `DMA_STRIDE_NARROW;

	logic [`DMA_AW-1:0] addr_q;
	logic [`DMA_AW-1:0] row_start;  // first word of the current row

	wire [`DMA_AW-1:0] stride   = ai.wide ? STRIDE_WIDE : STRIDE_NARROW;
	wire [`DMA_AW-1:0] row_next = row_start + stride;
	wire               new_row  = ai.align && ai.burst_end;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			addr_q    <= '0;
			row_start <= '0;
		end
		else if (ai.launch)
		begin
			addr_q    <= start_addr;
			row_start <= start_addr;
		end
		else if (ai.step)
		begin
			if (new_row)
			begin
				// rectangle moves on to its next row
				addr_q    <= row_next;
				row_start <= row_next;
			end
			else
				addr_q <= addr_q + 1'b1;  // wraps at DMA_AW bits
		end
	end

	assign ai.addr = addr_q;

endmodule

`default_nettype wire

//--- logic/dma_addr_if.sv
/*
 * Link between the transfer sequencer and one address generator
 */
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

interface dma_addr_if;

	logic               launch;     // load start address, one cycle
	logic               step;       // advance one word
	logic               burst_end;  // qualifies step
	logic               align;
	logic               wide;
	logic [`DMA_AW-1:0] addr;

	modport seq
	(
		output launch, step, burst_end, align, wide,
		input  addr
	);

	modport gen
	(
		input  launch, step, burst_end, align, wide,
		output addr
	);

endinterface

`default_nettype wire

//--- logic/dma_defs.svh
/*
 * DRAM DMA engine: widths, APB register map and row strides
 */
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// word address and counter widths
`define DMA_AW 21
`define DMA_LW 8

// APB byte offsets, one 32-bit word per register
`define DMA_OFS_SADDR 8'h00
`define DMA_OFS_DADDR 8'h04
`define DMA_OFS_LEN   8'h08
`define DMA_OFS_NUM   8'h0C
`define DMA_OFS_CTRL  8'h10
`define DMA_OFS_STAT  8'h14

// row strides in words for aligned addressing
`define DMA_STRIDE_WIDE   256
`define DMA_STRIDE_NARROW 512

`endif

//--- logic/dma_pkg.sv
/*
 * DRAM DMA engine types: transfer mode and the CTRL register layout
 */
`default_nettype none

package dma_pkg;

	// copy moves words, blit merges source over destination
	typedef enum logic
	{
		DMA_COPY = 1'b0,
		DMA_BLIT = 1'b1
	} dma_mode_e;

	// CTRL[3:0], mode sits in bit 0
	typedef struct packed
	{
		logic      wide;       // bytes and 256-word rows when set
		logic      dst_align;
		logic      src_align;
		dma_mode_e mode;
	} dma_ctrl_t;

endpackage

`default_nettype wire

//--- logic/dma_regs.sv
/*
 * APB register block of the DMA engine: addresses, burst sizes,
 * control and status, launch pulse on an idle CTRL write
 */
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module dma_regs
	import dma_pkg::*;
(
	input  wire                clk,
	input  wire                rst_n,
	input  wire                psel,
	input  wire                penable,
	input  wire                pwrite,
	input  wire [7:0]          paddr,
	input  wire [31:0]         pwdata,
	output logic [31:0]        prdata,
	output wire                pready,
	output wire                pslverr,
	input  wire                busy,
	output logic [`DMA_AW-1:0] saddr,
	output logic [`DMA_AW-1:0] daddr,
	output logic [`DMA_LW-1:0] len,
	output logic [`DMA_LW-1:0] num,
	output dma_ctrl_t          ctrl,
	output wire                start
);

	logic mapped;
	wire  access   = psel && penable;
	wire  is_stat  = paddr == `DMA_OFS_STAT;
	wire  wr_err   = !mapped || is_stat || busy;  // STAT is read only
	wire  wr_ok    = access && pwrite && !wr_err;

	assign pready  = 1'b1;  // no wait states
	assign pslverr = access && (pwrite ? wr_err : !mapped);

	// idle CTRL write kicks off a transfer
	assign start = wr_ok && (paddr == `DMA_OFS_CTRL);

	// read mux, also decodes the map
	always_comb
	begin
		mapped = 1'b1;
		prdata = '0;
		case (paddr)
			`DMA_OFS_SADDR: prdata[`DMA_AW-1:0] = saddr;
			`DMA_OFS_DADDR: prdata[`DMA_AW-1:0] = daddr;
			`DMA_OFS_LEN:   prdata[`DMA_LW-1:0] = len;
			`DMA_OFS_NUM:   prdata[`DMA_LW-1:0] = num;
			`DMA_OFS_CTRL:  prdata[$bits(dma_ctrl_t)-1:0] = ctrl;
			`DMA_OFS_STAT:  prdata[0] = busy;
			default:        mapped = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			saddr <= '0;
			daddr <= '0;
			len   <= '0;
			num   <= '0;
			ctrl  <= '0;
		end
		else if (wr_ok)
		begin
			case (paddr)
				`DMA_OFS_SADDR: saddr <= pwdata[`DMA_AW-1:0];
				`DMA_OFS_DADDR: daddr <= pwdata[`DMA_AW-1:0];
				`DMA_OFS_LEN:   len   <= pwdata[`DMA_LW-1:0];
				`DMA_OFS_NUM:   num   <= pwdata[`DMA_LW-1:0];
				`DMA_OFS_CTRL:  ctrl  <= dma_ctrl_t'(pwdata[$bits(dma_ctrl_t)-1:0]);
				default:        ;  // STAT never reaches here
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/dma_top.sv
/*
 * DRAM DMA engine top: APB registers, source and destination
 * address generators, transfer sequencer and end-of-transfer irq
 */
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module dma_top
	import dma_pkg::*;
(
	input  wire                clk,
	input  wire                rst_n,
	// APB
	input  wire                psel,
	input  wire                penable,
	input  wire                pwrite,
	input  wire [7:0]          paddr,
	input  wire [31:0]         pwdata,
	output wire [31:0]         prdata,
	output wire                pready,
	output wire                pslverr,
	// DRAM request port
	output wire                mem_req,
	output wire                mem_rnw,
	output wire [`DMA_AW-1:0]  mem_addr,
	output wire [15:0]         mem_wdata,
	input  wire [15:0]         mem_rdata,
	input  wire                mem_next,
	output wire                busy,
	output logic               irq
);

	wire [`DMA_AW-1:0] saddr;
	wire [`DMA_AW-1:0] daddr;
	wire [`DMA_LW-1:0] len;
	wire [`DMA_LW-1:0] num;
	dma_ctrl_t         ctrl;
	wire               start;
	wire               done;
	logic              done_q;  // high in the cycle busy has fallen

	dma_addr_if src_if ();
	dma_addr_if dst_if ();

	dma_regs u_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.busy    (busy),
		.saddr   (saddr),
		.daddr   (daddr),
		.len     (len),
		.num     (num),
		.ctrl    (ctrl),
		.start   (start)
	);

	dma_addr_gen u_src_gen (
		.clk        (clk),
		.rst_n      (rst_n),
		.start_addr (saddr),
		.ai         (src_if.gen)
	);

	dma_addr_gen u_dst_gen (
		.clk        (clk),
		.rst_n      (rst_n),
		.start_addr (daddr),
		.ai         (dst_if.gen)
	);

	dma_xfer_seq u_seq (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.ctrl      (ctrl),
		.len       (len),
		.num       (num),
		.busy      (busy),
		.done      (done),
		.src       (src_if.seq),
		.dst       (dst_if.seq),
		.mem_req   (mem_req),
		.mem_rnw   (mem_rnw),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata),
		.mem_next  (mem_next)
	);

	// irq one cycle after busy drops
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			done_q <= 1'b0;
			irq    <= 1'b0;
		end
		else
		begin
			done_q <= done;
			irq    <= done_q;
		end
	end

endmodule

`default_nettype wire

//--- logic/dma_xfer_seq.sv
/*
 * DMA transfer sequencer: phase FSM over the DRAM port, burst
 * counters, data register and the blit merge of source over destination
 */
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module dma_xfer_seq
	import dma_pkg::*;
(
	input  wire                clk,
	input  wire                rst_n,
	input  wire                start,
	input  wire dma_ctrl_t     ctrl,
	input  wire [`DMA_LW-1:0]  len,
	input  wire [`DMA_LW-1:0]  num,
	output wire                busy,
	output wire                done,
	dma_addr_if.seq            src,
	dma_addr_if.seq            dst,
	output wire                mem_req,
	output wire                mem_rnw,
	output wire [`DMA_AW-1:0]  mem_addr,
	output wire [15:0]         mem_wdata,
	input  wire [15:0]         mem_rdata,
	input  wire                mem_next
);

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_RD_SRC,
		ST_RD_DST,   // blit only
		ST_WR_DST
	} state_e;

	state_e             state;
	logic [`DMA_LW-1:0] b_ctr;  // words left in burst, minus one
	logic [`DMA_LW-1:0] n_ctr;  // bursts left, minus one
	logic [15:0]        data;

	wire burst_last = b_ctr == '0;
	wire xfer_last  = burst_last && (n_ctr == '0);
	wire rd_src_end = (state == ST_RD_SRC) && mem_next;
	wire rd_dst_end = (state == ST_RD_DST) && mem_next;
	wire wr_end     = (state == ST_WR_DST) && mem_next;

	// nonzero source units win, zero ones show the destination
	function automatic logic [15:0] blit_merge(
		input logic [15:0] s,
		input logic [15:0] d,
		input logic        wide
	);
		logic [15:0] m;
		m = d;
		if (wide)
		begin
			for (int i = 0; i < 2; i++)
				if (|s[i*8 +: 8])
					m[i*8 +: 8] = s[i*8 +: 8];
		end
		else
		begin
			for (int i = 0; i < 4; i++)
				if (|s[i*4 +: 4])
					m[i*4 +: 4] = s[i*4 +: 4];
		end
		return m;
	endfunction

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= ST_IDLE;
			b_ctr <= '0;
			n_ctr <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
					if (start)
					begin
						state <= ST_RD_SRC;
						b_ctr <= len;
						n_ctr <= num;
					end
				ST_RD_SRC:
					if (mem_next)
						state <= (ctrl.mode == DMA_BLIT) ? ST_RD_DST : ST_WR_DST;
				ST_RD_DST:
					if (mem_next)
						state <= ST_WR_DST;
				ST_WR_DST:
					if (mem_next)
					begin
						state <= xfer_last ? ST_IDLE : ST_RD_SRC;
						if (burst_last)
						begin
							b_ctr <= len;             // reload for next burst
							n_ctr <= n_ctr - 1'b1;
						end
						else
							b_ctr <= b_ctr - 1'b1;
					end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// word in flight
	always_ff @(posedge clk)
	begin
		if (rd_src_end)
			data <= mem_rdata;
		else if (rd_dst_end)
			data <= blit_merge(data, mem_rdata, ctrl.wide);
	end

	assign busy = state != ST_IDLE;
	assign done = wr_end && xfer_last;  // final write completes

	assign mem_req   = busy;
	assign mem_rnw   = state != ST_WR_DST;
	assign mem_addr  = (state == ST_RD_SRC) ? src.addr : dst.addr;
	assign mem_wdata = data;

	assign src.launch    = start;
	assign src.step      = rd_src_end;  // source moves after its read
	assign src.burst_end = burst_last;
	assign src.align     = ctrl.src_align;
	assign src.wide      = ctrl.wide;

	assign dst.launch    = start;
	assign dst.step      = wr_end;      // destination after its write
	assign dst.burst_end = burst_last;
	assign dst.align     = ctrl.dst_align;
	assign dst.wide      = ctrl.wide;

endmodule

`default_nettype wire

//--- project.f
+incdir+logic
logic/dma_pkg.sv
logic/dma_addr_if.sv
logic/dma_regs.sv
logic/dma_addr_gen.sv
logic/dma_xfer_seq.sv
logic/dma_top.sv
sim/dma_clk_gen.sv
sim/dma_props.sv
sim/dma_tb.sv

//--- sim/dma_clk_gen.sv
/*
 * Testbench clock and synchronous reset source
 */
`timescale 1ns/1ps
`default_nettype none

module dma_clk_gen #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

	// released on a falling edge after the reset cycles
	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- sim/dma_props.sv
/*
 * Bound DMA engine properties for the DRAM request under back-pressure,
 * irq width and irq timing against the fall of busy
 */
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module dma_props (
	input wire               clk,
	input wire               rst_n,
	input wire               mem_req,
	input wire               mem_rnw,
	input wire [`DMA_AW-1:0] mem_addr,
	input wire [15:0]        mem_wdata,
	input wire               mem_next,
	input wire               busy,
	input wire               irq
);

	int fail_count = 0;  // read by the testbench at the end

	req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req && !mem_next |=>
			mem_req && $stable(mem_rnw) && $stable(mem_addr) && $stable(mem_wdata))
	else
	begin
		fail_count++;
		$error("DRAM request changed while the access was stalled");
	end

	irq_width: assert property (@(posedge clk) disable iff (!rst_n) irq |=> !irq)
	else
	begin
		fail_count++;
		$error("irq stayed high for more than one cycle");
	end

	// busy high two cycles back and low in the cycle before irq
	irq_timing: assert property (@(posedge clk) disable iff (!rst_n)
		irq |-> !$past(busy) && $past(busy, 2))
	else
	begin
		fail_count++;
		$error("irq did not come in the cycle after busy fell");
	end

endmodule

bind dma_top dma_props u_props (
	.clk       (clk),
	.rst_n     (rst_n),
	.mem_req   (mem_req),
	.mem_rnw   (mem_rnw),
	.mem_addr  (mem_addr),
	.mem_wdata (mem_wdata),
	.mem_next  (mem_next),
	.busy      (busy),
	.irq       (irq)
);

`default_nettype wire

//--- sim/dma_tb.sv
/*
 * DMA engine testbench with APB programming, a stalling sparse DRAM model,
 * reference memory image and full image compare after each transfer
 */
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module dma_tb
	import dma_pkg::*;
();

	localparam int PERIOD      = 20;
	localparam int MAX_STALL   = 3;    // extra wait cycles per DRAM access
	localparam int MAX_WORDS   = 224;  // upper bound over all transfers below
	localparam int WATCHDOG_NS = MAX_WORDS * 3 * (MAX_STALL + 1) * PERIOD + 20000;

	wire                clk;
	wire                rst_n;
	logic               psel;
	logic               penable;
	logic               pwrite;
	logic [7:0]         paddr;
	logic [31:0]        pwdata;
	wire  [31:0]        prdata;
	wire                pready;
	wire                pslverr;
	wire                mem_req;
	wire                mem_rnw;
	wire  [`DMA_AW-1:0] mem_addr;
	wire  [15:0]        mem_wdata;
	logic [15:0]        mem_rdata = '0;
	logic               mem_next = 1'b0;
	wire                busy;
	wire                irq;

	logic [15:0] mem [int];      // sparse DRAM where absent words read the fill pattern
	logic [15:0] exp_mem [int];  // expected image after the current transfer
	integer      seed = 32'h52b1;
	int          stall_left = 0;
	logic        in_access = 1'b0;
	int          irq_count = 0;
	int          checks = 0;
	int          errors = 0;
	event        compare_req;
	event        compare_ack;

	dma_clk_gen #(.PERIOD(PERIOD), .RESET_CYCLES(4)) u_clk_gen (.clk(clk), .rst_n(rst_n));

	dma_top u_dma_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.mem_req   (mem_req),
		.mem_rnw   (mem_rnw),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata),
		.mem_next  (mem_next),
		.busy      (busy),
		.irq       (irq)
	);

	function automatic logic [15:0] fill_word(input logic [`DMA_AW-1:0] a);
		return a[15:0] ^ {a[20:16], a[20:16], a[20:16], 1'b1};
	endfunction

	function automatic logic [15:0] mem_word(input logic [`DMA_AW-1:0] a);
		return mem.exists(int'(a)) ? mem[int'(a)] : fill_word(a);
	endfunction

	function automatic logic [15:0] exp_word(input logic [`DMA_AW-1:0] a);
		return exp_mem.exists(int'(a)) ? exp_mem[int'(a)] : fill_word(a);
	endfunction

	// source nibble (or byte when wide) shows through unless it is zero
	function automatic logic [15:0] blend(input logic [15:0] s, input logic [15:0] d,
		input logic wide);
		logic [15:0] take;  // bits taken from the source
		logic        nz;
		take = '0;
		for (int i = 0; i < 4; i++)
		begin
			nz = wide ? |s[(i / 2) * 8 +: 8] : |s[i * 4 +: 4];
			if (nz)
				take[i * 4 +: 4] = 4'hf;
		end
		return (s & take) | (d & ~take);
	endfunction

	// walks the transfer word by word over exp_mem, which holds the pre-transfer image
	function automatic void build_expected(input logic [`DMA_AW-1:0] sa,
		input logic [`DMA_AW-1:0] da, input logic [`DMA_LW-1:0] ln,
		input logic [`DMA_LW-1:0] nm, input dma_ctrl_t c);
		logic [`DMA_AW-1:0] s;
		logic [`DMA_AW-1:0] d;
		logic [`DMA_AW-1:0] s_row;
		logic [`DMA_AW-1:0] d_row;
		logic [`DMA_AW-1:0] stride;
		logic [15:0]        w;
		s      = sa;
		d      = da;
		s_row  = sa;
		d_row  = da;
		stride = c.wide ? `DMA_STRIDE_WIDE : `DMA_STRIDE_NARROW;
		for (int b = 0; b <= nm; b++)
			for (int i = 0; i <= ln; i++)
			begin
				w = exp_word(s);
				if (c.mode == DMA_BLIT)
					w = blend(w, exp_word(d), c.wide);
				exp_mem[int'(d)] = w;
				if (i == ln && c.src_align)
				begin
					s_row = s_row + stride;  // next rectangle row
					s     = s_row;
				end
				else
					s = s + 1'b1;
				if (i == ln && c.dst_align)
				begin
					d_row = d_row + stride;
					d     = d_row;
				end
				else
					d = d + 1'b1;
			end
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic require(input logic cond, input string what);
		checks++;
		assert (cond)
		else
		begin
			errors++;
			$display("error at %0t: %s", $time, what);
		end
	endtask

	// one APB access in setup and access phase without wait states
	task automatic apb_transfer(input logic wr, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		#(PERIOD / 4);  // response settled mid low phase
		rdata = prdata;
		err   = pslverr;
		compare_value("pready", 32'(pready), 32'h1);
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic reg_write(input logic [7:0] addr, input logic [31:0] data,
		input logic exp_err);
		logic [31:0] rd;
		logic        err;
		apb_transfer(1'b1, addr, data, rd, err);
		compare_value($sformatf("pslverr (write 0x%02h)", addr), 32'(err), 32'(exp_err));
	endtask

	task automatic reg_read(input logic [7:0] addr, input logic [31:0] exp,
		input logic exp_err);
		logic [31:0] rd;
		logic        err;
		apb_transfer(1'b0, addr, 32'h0, rd, err);
		compare_value($sformatf("pslverr (read 0x%02h)", addr), 32'(err), 32'(exp_err));
		if (!exp_err)
			compare_value($sformatf("prdata (0x%02h)", addr), rd, exp);
	endtask

	task automatic preload(input logic [`DMA_AW-1:0] base, input int count,
		input logic sparse);
		logic [`DMA_AW-1:0] a;
		logic [31:0]        r;
		logic [15:0]        w;
		a = base;
		for (int i = 0; i < count; i++)
		begin
			r = $random(seed);
			w = r[15:0];
			if (sparse)
				for (int j = 0; j < 4; j++)
					if (r[16 + j])
						w[j * 4 +: 4] = 4'h0;  // transparent nibble
			mem[int'(a)] = w;
			a = a + 1'b1;
		end
	endtask

	task automatic run_transfer(input logic [`DMA_AW-1:0] sa, input logic [`DMA_AW-1:0] da,
		input logic [`DMA_LW-1:0] ln, input logic [`DMA_LW-1:0] nm, input dma_ctrl_t c,
		input logic poke);
		int irq_before;
		reg_write(`DMA_OFS_SADDR, 32'(sa), 1'b0);
		reg_write(`DMA_OFS_DADDR, 32'(da), 1'b0);
		reg_write(`DMA_OFS_LEN, 32'(ln), 1'b0);
		reg_write(`DMA_OFS_NUM, 32'(nm), 1'b0);
		exp_mem = mem;
		build_expected(sa, da, ln, nm, c);
		irq_before = irq_count;
		reg_write(`DMA_OFS_CTRL, 32'(c), 1'b0);
		require(busy === 1'b1, "busy not high after the CTRL write");
		if (poke)
		begin
			reg_read(`DMA_OFS_STAT, 32'h1, 1'b0);
			reg_write(`DMA_OFS_CTRL, 32'(c) ^ 32'h1, 1'b1);  // mode flip must be ignored
			reg_write(`DMA_OFS_SADDR, 32'h0, 1'b1);
		end
		while (irq !== 1'b1)
			@(negedge clk);
		repeat (3) @(negedge clk);
		require(busy === 1'b0, "busy still high after the interrupt");
		compare_value("irq pulses", 32'(irq_count - irq_before), 32'h1);
		-> compare_req;
		@(compare_ack);
	endtask

	// DRAM model answering on the falling edge with a random stall per access
	always @(negedge clk)
	begin
		mem_next = 1'b0;
		if (!mem_req)
			in_access = 1'b0;
		else
		begin
			if (!in_access)
			begin
				stall_left = {$random(seed)} % (MAX_STALL + 1);
				in_access  = 1'b1;
			end
			if (stall_left > 0)
				stall_left--;
			else
			begin
				mem_next  = 1'b1;  // completes on the coming rising edge
				in_access = 1'b0;
				if (mem_rnw)
					mem_rdata = mem_word(mem_addr);
				else
					mem[int'(mem_addr)] = mem_wdata;
			end
		end
	end

	always @(negedge clk)
		if (irq === 1'b1)
			irq_count++;

	// whole image against the reference
	initial
	forever
	begin
		@(compare_req);
		compare_value("mem word count", 32'(mem.num()), 32'(exp_mem.num()));
		foreach (exp_mem[a])
			compare_value($sformatf("mem[%06h]", a), 32'(mem_word(a)), 32'(exp_mem[a]));
		-> compare_ack;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: transfers did not finish within %0d ns", WATCHDOG_NS);
		$display("Checks failed");
		$finish;
	end

	initial
	begin
		logic [31:0]        rnd;
		logic [`DMA_AW-1:0] base;
		logic [`DMA_LW-1:0] ln;
		logic [`DMA_LW-1:0] nm;
		dma_ctrl_t          c;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		wait (rst_n === 1'b1);

		// register access and error responses
		reg_write(`DMA_OFS_SADDR, 32'h001A_BCDE, 1'b0);
		reg_read(`DMA_OFS_SADDR, 32'h001A_BCDE, 1'b0);
		reg_write(`DMA_OFS_DADDR, 32'hFFFF_FFFF, 1'b0);
		reg_read(`DMA_OFS_DADDR, 32'h001F_FFFF, 1'b0);
		reg_write(`DMA_OFS_LEN, 32'h1234_56A5, 1'b0);
		reg_read(`DMA_OFS_LEN, 32'h0000_00A5, 1'b0);
		reg_write(`DMA_OFS_NUM, 32'h0000_013C, 1'b0);
		reg_read(`DMA_OFS_NUM, 32'h0000_003C, 1'b0);
		reg_read(`DMA_OFS_STAT, 32'h0, 1'b0);
		reg_write(`DMA_OFS_STAT, 32'h1, 1'b1);
		reg_write(8'h18, 32'h5, 1'b1);
		reg_read(8'h18, 32'h0, 1'b1);
		reg_read(8'h02, 32'h0, 1'b1);

		// linear copy of random size
		rnd  = $random(seed);
		base = {9'h0, rnd[11:0]};
		ln   = {4'h0, rnd[15:12]};
		nm   = {6'h0, rnd[17:16]};
		preload(base, 64, 1'b0);
		c = '0;
		run_transfer(base, base + 21'h4000, ln, nm, c, 1'b0);

		// aligned rectangles with narrow then wide rows
		for (int w = 0; w < 2; w++)
		begin
			c           = '0;
			c.src_align = 1'b1;
			c.dst_align = 1'b1;
			c.wide      = w[0];
			run_transfer(21'h01000, 21'h40000, 8'd7, 8'd3, c, 1'b0);
		end

		// blit per nibble and then per byte
		for (int w = 0; w < 2; w++)
		begin
			preload(21'h08000, 16, 1'b1);
			preload(21'h09000, 16, 1'b0);
			c      = '0;
			c.mode = DMA_BLIT;
			c.wide = w[0];
			run_transfer(21'h08000, 21'h09000, 8'd15, 8'd0, c, 1'b0);
		end

		// source wrapping past the top while writes during busy get refused
		preload(21'h1FFFF0, 64, 1'b0);
		c = '0;
		run_transfer(21'h1FFFF0, 21'h0C000, 8'd31, 8'd1, c, 1'b1);

		$display("%0d checks, %0d errors, %0d assertion failures",
			checks, errors, u_dma_top.u_props.fail_count);
		if (errors == 0 && u_dma_top.u_props.fail_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire
